// File: dv/axi_mem_model.sv
`timescale 1ns/10ps

module axi_mem_model
  import axi_rd_pkg::*;
  import frame_rd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_arvalid,
  input  axi_ar_t   i_ar,
  input  logic      i_rready,
  input  logic      i_err_en,
  input  axi_addr_t i_err_addr,
  output logic      o_arready,
  output logic      o_rvalid,
  output axi_r_t    o_r
);

  axi_addr_t ar_q[$];
  axi_addr_t cur_addr;
  logic      busy;
  logic      err_burst;
  int        beat_idx;
  int        delay;

  // lane k of the beat at byte address a holds a + 4k
  function automatic axi_data_t fill_beat(axi_addr_t a);
    axi_data_t d;
    for (int k = 0; k < AXI_DATA_W / 32; k++) begin
      d[32*k +: 32] = a + axi_addr_t'(4 * k);
    end
    return d;
  endfunction

  // **************************************************
  // AR accept and R burst playback
  // **************************************************
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
      o_r       <= '0;
      busy      <= 1'b0;
      err_burst <= 1'b0;
      beat_idx  <= 0;
      delay     <= 0;
      cur_addr  <= '0;
      ar_q.delete();
    end else begin
      if (i_arvalid && o_arready) begin
        ar_q.push_back(i_ar.addr);
      end
      // random stalls, short request queue
      o_arready <= (ar_q.size() < 4) && ($urandom_range(0, 2) != 0);
      if (!o_rvalid || i_rready) begin
        o_rvalid <= 1'b0;
        if (busy && delay > 0) begin
          delay <= delay - 1;
        end else if (busy) begin
          o_rvalid <= 1'b1;
          o_r.data <= fill_beat(cur_addr + axi_addr_t'(beat_idx * BEAT_BYTES));
          o_r.resp <= err_burst ? SLVERR : OKAY;
          o_r.last <= (beat_idx == BURST_LEN - 1);
          beat_idx <= beat_idx + 1;
          busy     <= (beat_idx != BURST_LEN - 1);
        end else if (ar_q.size() > 0) begin
          // next burst starts 2 to 6 cycles from here
          cur_addr  <= ar_q[0];
          err_burst <= i_err_en && (ar_q[0] == i_err_addr);
          void'(ar_q.pop_front());
          busy      <= 1'b1;
          beat_idx  <= 0;
          delay     <= $urandom_range(1, 5);
        end
      end
    end
  end

endmodule

// File: dv/tb_frame_reader.sv
`timescale 1ns/10ps

module tb_frame_reader
  import axi_rd_pkg::*;
  import frame_rd_pkg::*;
();

  localparam int NUM_FRAMES     = 5;
  // half-rate back-pressure plus memory delay and some margin
  localparam int FRAME_CYCLES   = 800;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      i_start;
  logic      i_ready = 1'b0;
  logic      arready;
  logic      rvalid;
  axi_r_t    r_beat;
  logic      arvalid;
  axi_ar_t   ar;
  axi_id_t   arid;
  logic      rready;
  logic      o_valid;
  beat_t     o_beat;
  logic      o_busy;
  logic      o_rd_err;
  logic      err_en;
  axi_addr_t err_addr;
  logic      random_ready;
  int        exp_total;
  int        exp_ars;
  int        out_cnt = 0;
  int        ar_cnt = 0;
  int        cycle_cnt = 0;
  int        error_count = 0;

  always #50 clk = ~clk;

  frame_reader_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_start   (i_start),
    .i_arready (arready),
    .i_rvalid  (rvalid),
    .i_r       (r_beat),
    .i_ready   (i_ready),
    .o_arvalid (arvalid),
    .o_ar      (ar),
    .o_arid    (arid),
    .o_rready  (rready),
    .o_valid   (o_valid),
    .o_beat    (o_beat),
    .o_busy    (o_busy),
    .o_rd_err  (o_rd_err)
  );

  axi_mem_model u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_arvalid  (arvalid),
    .i_ar       (ar),
    .i_rready   (rready),
    .i_err_en   (err_en),
    .i_err_addr (err_addr),
    .o_arready  (arready),
    .o_rvalid   (rvalid),
    .o_r        (r_beat)
  );

  // **************************************************
  // reference model
  // **************************************************
  function automatic beat_t ref_beat(int n);
    beat_t     b;
    axi_addr_t a;
    a = FRAME_BASE + axi_addr_t'(n * BEAT_BYTES);
    for (int k = 0; k < 4; k++) begin
      b.data[32*k +: 32] = a + axi_addr_t'(4 * k);
    end
    b.last = (n == FRAME_BEATS - 1);
    return b;
  endfunction

  function automatic axi_ar_t ref_ar(int n);
    axi_ar_t e;
    e.addr  = FRAME_BASE + axi_addr_t'(n * BURST_BYTES);
    e.len   = 8'd7;
    e.size  = 3'd4;
    e.burst = INCR;
    return e;
  endfunction

  task automatic report_failure();
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_beat(beat_t exp, beat_t got);
    if (got !== exp) begin
      $display("Error at %0t ns: o_beat expected %h got %h", $time, exp, got);
      error_count++;
      report_failure();
    end
  endtask

  task automatic check_ar(axi_ar_t exp, axi_ar_t got);
    if (got !== exp) begin
      $display("Error at %0t ns: o_ar expected %h got %h", $time, exp, got);
      error_count++;
      report_failure();
    end
  endtask

  task automatic check_id(axi_id_t exp, axi_id_t got);
    if (got !== exp) begin
      $display("Error at %0t ns: o_arid expected %0d got %0d", $time, exp, got);
      error_count++;
      report_failure();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic got);
    if (got !== exp) begin
      $display("Error at %0t ns: %s expected %b got %b", $time, name, exp, got);
      error_count++;
      report_failure();
    end
  endtask

  task automatic check_count(string name, int exp, int got);
    if (got != exp) begin
      $display("Error at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
      error_count++;
      report_failure();
    end
  endtask

  // **************************************************
  // stimulus helpers
  // **************************************************
  task automatic pulse_start();
    @(posedge clk);
    i_start <= 1'b1;
    repeat (3) @(posedge clk);
    i_start <= 1'b0;
  endtask

  task automatic run_frame();
    exp_total += FRAME_BEATS;
    exp_ars   += FRAME_BURSTS;
    pulse_start();
    @(negedge clk);
    check_flag("o_busy", 1'b1, o_busy);
  endtask

  // busy drops on the edge that takes the last beat
  task automatic wait_frame();
    while (out_cnt < exp_total) begin
      @(negedge clk);
    end
    check_flag("o_busy", 1'b0, o_busy);
    check_count("AR transfers", exp_ars, ar_cnt);
  endtask

  always @(posedge clk) begin
    if (random_ready) begin
      i_ready <= ($urandom_range(0, 1) == 1);
    end else begin
      i_ready <= 1'b1;
    end
  end

  // **************************************************
  // compare process and watchdog
  // **************************************************
  always @(posedge clk) begin
    if (rst_n) begin
      check_flag("o_rready", 1'b1, rready);
      if (o_valid && i_ready) begin
        check_beat(ref_beat(out_cnt % FRAME_BEATS), o_beat);
        out_cnt++;
      end
      if (arvalid && arready) begin
        check_ar(ref_ar(ar_cnt % FRAME_BURSTS), ar);
        check_id(4'd1, arid);
        ar_cnt++;
      end
      if (ar_cnt * BURST_LEN - out_cnt > FIFO_DEPTH) begin
        $display("Error at %0t ns: more beats requested than the FIFO can hold", $time);
        report_failure();
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run hung for %0d cycles", cycle_cnt);
      report_failure();
    end
  end

  initial begin
    void'($urandom(32'haf56));
    rst_n        = 1'b0;
    i_start      = 1'b0;
    err_en       = 1'b0;
    err_addr     = '0;
    random_ready = 1'b0;
    exp_total    = 0;
    exp_ars      = 0;
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_flag("o_arvalid", 1'b0, arvalid);
    check_flag("o_valid", 1'b0, o_valid);
    check_flag("o_busy", 1'b0, o_busy);
    check_flag("o_rd_err", 1'b0, o_rd_err);
    @(posedge clk);
    rst_n <= 1'b1;

    // ready held high
    run_frame();
    wait_frame();
    check_flag("o_rd_err", 1'b0, o_rd_err);

    // random back-pressure from here on
    random_ready = 1'b1;
    run_frame();
    wait_frame();

    // a start during the frame must be dropped
    run_frame();
    repeat (20) @(negedge clk);
    pulse_start();
    // and again once the last burst is out and the frame drains
    while (ar_cnt < exp_ars) begin
      @(negedge clk);
    end
    pulse_start();
    wait_frame();
    repeat (100) @(negedge clk);
    check_count("o_valid transfers", exp_total, out_cnt);
    check_count("AR transfers", exp_ars, ar_cnt);
    check_flag("o_rd_err", 1'b0, o_rd_err);

    // SLVERR on the fourth burst
    err_addr = FRAME_BASE + axi_addr_t'(3 * BURST_BYTES);
    err_en   = 1'b1;
    run_frame();
    wait_frame();
    check_flag("o_rd_err", 1'b1, o_rd_err);
    err_en = 1'b0;
    run_frame();
    wait_frame();
    check_flag("o_rd_err", 1'b0, o_rd_err);

    if (error_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      report_failure();
    end
  end

endmodule

// File: rtl/axi_ar_issue.sv
`timescale 1ns/10ps

module axi_ar_issue
  import axi_rd_pkg::*;
  import frame_rd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_req_valid,
  input  burst_req_t i_req,
  input  logic       i_arready,
  input  logic       i_pop,
  output logic       o_req_ready,
  output logic       o_arvalid,
  output axi_ar_t    o_ar
);

  localparam logic [CREDIT_W-1:0] BURST_CREDIT = CREDIT_W'(BURST_LEN);
  localparam logic [CREDIT_W-1:0] FULL_CREDIT  = CREDIT_W'(FIFO_DEPTH);

  logic [CREDIT_W-1:0] credit;
  logic                credit_ok;
  logic                ar_fire;

  // **************************************************
  // fifo credit
  // **************************************************
  // room for a whole burst must be free before the AR goes out,
  // since the R channel cannot be stalled
  assign credit_ok = (credit >= BURST_CREDIT);
  assign ar_fire   = o_arvalid & i_arready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit <= FULL_CREDIT;
    end else begin
      case ({ar_fire, i_pop})
        2'b10:   credit <= credit - BURST_CREDIT;
        2'b11:   credit <= credit - BURST_CREDIT + 1'b1;
        2'b01:   credit <= credit + 1'b1;
        default: credit <= credit;
      endcase
    end
  end

  // **************************************************
  // AR channel
  // **************************************************
  // credit only drops on an AR transfer, so a raised
  // arvalid holds until accepted
  assign o_arvalid   = i_req_valid & credit_ok;
  assign o_req_ready = i_arready & credit_ok;

  always_comb begin
    o_ar.addr  = i_req.addr;
    o_ar.len   = AR_LEN_C;
    o_ar.size  = AR_SIZE_C;
    o_ar.burst = AR_BURST_C;
  end

endmodule

// File: rtl/axi_r_capture.sv
`timescale 1ns/10ps

module axi_r_capture
  import axi_rd_pkg::*;
  import frame_rd_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   i_start_frame,
  input  logic   i_rvalid,
  input  axi_r_t i_r,
  output logic   o_push,
  output beat_t  o_beat,
  output logic   o_rd_err
);

  logic [BEAT_CNT_W-1:0] beat_cnt;
  logic                  frame_end;

  // last beat of the frame by count, rlast only ends a burst
  assign frame_end = (int'(beat_cnt) == FRAME_BEATS - 1);

  // **************************************************
  // beat counter and error flag
  // **************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
      o_push   <= 1'b0;
      o_rd_err <= 1'b0;
    end else begin
      o_push <= i_rvalid;
      if (i_start_frame) begin
        beat_cnt <= '0;
      end else if (i_rvalid) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
      // sticky until the next frame
      if (i_rvalid && i_r.resp != OKAY) begin
        o_rd_err <= 1'b1;
      end else if (i_start_frame) begin
        o_rd_err <= 1'b0;
      end
    end
  end

  // beat register
  always_ff @(posedge clk) begin
    if (i_rvalid) begin
      o_beat.data <= i_r.data;
      o_beat.last <= frame_end;
    end
  end

endmodule

// File: rtl/axi_rd_pkg.sv
package axi_rd_pkg;

  // bus widths
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 128;
  localparam int AXI_ID_W   = 4;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_ID_W-1:0]   axi_id_t;

  typedef enum logic [1:0] {
    FIXED = 2'd0,
    INCR  = 2'd1,
    WRAP  = 2'd2
  } axi_burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    EXOKAY = 2'd1,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } axi_resp_e;

  // AR payload without id, the id is fixed
  typedef struct packed {
    axi_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    axi_burst_e burst;
  } axi_ar_t;

  typedef struct packed {
    axi_data_t data;
    axi_resp_e resp;
    logic      last;
  } axi_r_t;

  // fixed AR fields, len covers 8-beat bursts of 16 bytes
  localparam axi_id_t    AR_ID_C    = 4'd1;
  localparam logic [2:0] AR_SIZE_C  = 3'd4;
  localparam axi_burst_e AR_BURST_C = INCR;
  localparam logic [7:0] AR_LEN_C   = 8'd7;

endpackage

// File: rtl/burst_req_gen.sv
`timescale 1ns/10ps

module burst_req_gen
  import axi_rd_pkg::*;
  import frame_rd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_start,
  input  logic       i_req_ready,
  input  logic       i_frame_done,
  output logic       o_req_valid,
  output burst_req_t o_req,
  output logic       o_frame_active
);

  logic [1:0]             start_sync;
  logic                   start_prev;
  logic                   start_edge;
  logic                   req_fire;
  logic                   draining;
  logic [BURST_CNT_W-1:0] burst_idx;
  rd_state_e              state;

  // **************************************************
  // start input sync and edge detect
  // **************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_sync <= 2'b00;
      start_prev <= 1'b0;
    end else begin
      start_sync <= {start_sync[0], i_start};
      start_prev <= start_sync[1];
    end
  end

  assign start_edge = start_sync[1] & ~start_prev;
  assign req_fire   = o_req_valid & i_req_ready;

  // **************************************************
  // burst request sequence
  // **************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      o_req_valid <= 1'b0;
      burst_idx   <= '0;
      draining    <= 1'b0;
    end else begin
      // frame fully out of the fifo
      if (i_frame_done) begin
        draining <= 1'b0;
      end
      case (state)
        IDLE: begin
          // a start during a busy frame is dropped
          if (start_edge && !draining) begin
            state       <= ISSUE;
            o_req_valid <= 1'b1;
            burst_idx   <= '0;
          end
        end
        ISSUE: begin
          if (req_fire) begin
            if (o_req.last_burst) begin
              state       <= IDLE;
              o_req_valid <= 1'b0;
              draining    <= 1'b1;
            end else begin
              burst_idx <= burst_idx + 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (state == IDLE && start_edge && !draining) begin
      o_req.addr       <= FRAME_BASE;
      o_req.last_burst <= (FRAME_BURSTS == 1);
    end else if (state == ISSUE && req_fire) begin
      o_req.addr       <= o_req.addr + axi_addr_t'(BURST_BYTES);
      o_req.last_burst <= (int'(burst_idx) + 1 == FRAME_BURSTS - 1);
    end
  end

  assign o_frame_active = (state == ISSUE) | draining;

endmodule

// File: rtl/frame_rd_pkg.sv
package frame_rd_pkg;

  import axi_rd_pkg::*;

  // frame geometry
  localparam int BURST_LEN    = int'(AR_LEN_C) + 1;
  localparam int BEAT_BYTES   = 16;
  localparam int BURST_BYTES  = BURST_LEN * BEAT_BYTES;
  localparam int FRAME_BEATS  = 64;
  localparam int FRAME_BURSTS = FRAME_BEATS / BURST_LEN;
  localparam axi_addr_t FRAME_BASE = 32'h0000_1000;

  // output buffering and counter widths
  localparam int FIFO_DEPTH  = 32;
  localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
  localparam int CREDIT_W    = $clog2(FIFO_DEPTH + 1);
  localparam int BEAT_CNT_W  = $clog2(FRAME_BEATS);
  localparam int BURST_CNT_W = $clog2(FRAME_BURSTS);

  typedef struct packed {
    axi_addr_t addr;
    logic      last_burst;
  } burst_req_t;

  // one beat of the output stream
  typedef struct packed {
    axi_data_t data;
    logic      last;
  } beat_t;

  typedef enum logic {
    IDLE  = 1'b0,
    ISSUE = 1'b1
  } rd_state_e;

endpackage

// File: rtl/frame_reader_top.sv
`timescale 1ns/10ps

module frame_reader_top
  import axi_rd_pkg::*;
  import frame_rd_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_start,
  input  logic    i_arready,
  input  logic    i_rvalid,
  input  axi_r_t  i_r,
  input  logic    i_ready,
  output logic    o_arvalid,
  output axi_ar_t o_ar,
  output axi_id_t o_arid,
  output logic    o_rready,
  output logic    o_valid,
  output beat_t   o_beat,
  output logic    o_busy,
  output logic    o_rd_err
);

  logic       req_valid;
  logic       req_ready;
  burst_req_t req;
  logic       frame_done;
  logic       start_frame;
  logic       push;
  beat_t      push_beat;
  logic       pop;

  // fixed AXI fields
  assign o_rready = 1'b1;
  assign o_arid   = AR_ID_C;

  // first burst of a frame restarts the beat count
  assign start_frame = req_valid & req_ready & (req.addr == FRAME_BASE);
  assign frame_done  = o_valid & i_ready & o_beat.last;

  burst_req_gen u_req_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_start        (i_start),
    .i_req_ready    (req_ready),
    .i_frame_done   (frame_done),
    .o_req_valid    (req_valid),
    .o_req          (req),
    .o_frame_active (o_busy)
  );

  axi_ar_issue u_ar_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_req_valid (req_valid),
    .i_req       (req),
    .i_arready   (i_arready),
    .i_pop       (pop),
    .o_req_ready (req_ready),
    .o_arvalid   (o_arvalid),
    .o_ar        (o_ar)
  );

  axi_r_capture u_r_capture (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start_frame (start_frame),
    .i_rvalid      (i_rvalid),
    .i_r           (i_r),
    .o_push        (push),
    .o_beat        (push_beat),
    .o_rd_err      (o_rd_err)
  );

  stream_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_push  (push),
    .i_beat  (push_beat),
    .i_ready (i_ready),
    .o_valid (o_valid),
    .o_beat  (o_beat),
    .o_pop   (pop)
  );

endmodule

// File: rtl/stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo
  import frame_rd_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  i_push,
  input  beat_t i_beat,
  input  logic  i_ready,
  output logic  o_valid,
  output beat_t o_beat,
  output logic  o_pop
);

  beat_t              mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               buf_empty;
  logic               load;
  logic               bypass;
  logic               wr_en;
  logic               rd_en;

  assign buf_empty = (count == '0);
  // output stage free, or emptied this cycle
  assign load      = ~o_valid | i_ready;
  // straight to the output stage when the buffer is empty
  assign bypass    = i_push & buf_empty & load;
  assign wr_en     = i_push & ~bypass;
  assign rd_en     = load & ~buf_empty;
  assign o_pop     = o_valid & i_ready;

  // **************************************************
  // circular buffer
  // **************************************************
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_beat;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + wr_en - rd_en;
    end
  end

  // registered output stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
    end else if (load) begin
      o_valid <= rd_en | bypass;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      o_beat <= mem[rd_ptr];
    end else if (bypass) begin
      o_beat <= i_beat;
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the frame reader testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_frame_reader \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
  echo "RESULT: PASS"
  exit 0
fi
echo "RESULT: FAIL"
exit 1

// File: src.f
rtl/axi_rd_pkg.sv
rtl/frame_rd_pkg.sv
rtl/burst_req_gen.sv
rtl/axi_ar_issue.sv
rtl/axi_r_capture.sv
rtl/stream_fifo.sv
rtl/frame_reader_top.sv
dv/axi_mem_model.sv
dv/tb_frame_reader.sv
